//--- hdl/qsfp_mgmt_defines.svh
// sizing and timing constants for the QSFP cage management core, included by its modules
`ifndef QSFP_MGMT_DEFINES_SVH
`define QSFP_MGMT_DEFINES_SVH

// number of QSFP28 cages handled by one core
`define QSFP_PORT_CNT 4

// flip-flop stages between the cage pins and the core logic
`define QSFP_SYNC_STAGES 2

// cycles that resetl stays low after a module is seen
`define QSFP_RESET_HOLD_CYCLES 16

// cycles spent in low-power mode before the port counts as ready
`define QSFP_INIT_WAIT_CYCLES 64

// interval counter width that must hold both intervals above
`define QSFP_TIMER_WIDTH 16

// prescaler bit used as the LED blink source
`define QSFP_BLINK_BIT 3

`endif

//--- hdl/qsfp_pin_pkg.sv
// pin-level types for the QSFP cage sideband signals, imported by the management core
`default_nettype none

package qsfp_pin_pkg;

    // pins driven by the module towards the FPGA
    // both are active low on the connector
    typedef struct packed {
        logic modprsl_l;
        logic intl_l;
    } qsfp_pins_in_t;

    // pins driven by the FPGA towards the module
    typedef struct packed {
        // module runs while high
        logic resetl;
        // high keeps the module in low-power mode
        logic lpmode;
    } qsfp_pins_out_t;

    // idle levels for an empty cage
    localparam qsfp_pins_in_t QSFP_PINS_IN_IDLE = '{
        modprsl_l: 1'b1,
        intl_l:    1'b1
    };

endpackage

`default_nettype wire

//--- hdl/qsfp_ctrl_pkg.sv
// port sequencing types shared by the cage FSMs and the LED driver
`default_nettype none

package qsfp_ctrl_pkg;

    // per-cage bring-up sequence
    typedef enum logic [1:0] {
        // no module in the cage
        ST_ABSENT = 2'd0,
        // module present, resetl held low
        ST_RESET  = 2'd1,
        // out of reset, still in low-power mode
        ST_INIT   = 2'd2,
        // fully powered and usable
        ST_READY  = 2'd3
    } port_state_e;

    // status reported by each sequencer
    typedef struct packed {
        port_state_e state;
        // module interrupt that is only valid while ready
        logic        irq;
    } port_status_t;

endpackage

`default_nettype wire

//--- hdl/pin_sync.sv
// multi-stage synchronizer bringing asynchronous cage pins into the 125 MHz domain
`timescale 1ns/100ps
`default_nettype none

module pin_sync #(
    parameter int WIDTH  = 1,
    parameter int STAGES = 2
) (
    input  wire logic             clk_125mhz_int,
    input  wire logic             rst_i,
    input  wire logic [WIDTH-1:0] async_i,
    output logic      [WIDTH-1:0] sync_o
);

    // stage 0 takes the raw pins, the last stage feeds the core
    logic [STAGES-1:0][WIDTH-1:0] sync_q;

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_i) begin
            // all ones reads as empty cage without interrupt
            sync_q <= '1;
        end else begin
            sync_q[0] <= async_i;
            for (int s = 1; s < STAGES; s++) begin
                sync_q[s] <= sync_q[s-1];
            end
        end
    end

    assign sync_o = sync_q[STAGES-1];

endmodule

`default_nettype wire

//--- hdl/port_timer.sv
// per-port interval timer, loaded by the sequencer and pulsing once when the interval ends
`timescale 1ns/100ps
`default_nettype none

`include "qsfp_mgmt_defines.svh"

module port_timer (
    input  wire logic                         clk_125mhz_int,
    input  wire logic                         rst_i,
    input  wire logic                         load_i,
    input  wire logic [`QSFP_TIMER_WIDTH-1:0] load_val_i,
    output logic                              expired_o
);

    // zero means idle
    logic [`QSFP_TIMER_WIDTH-1:0] count_q;
    logic                         expired_q;

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_i) begin
            count_q   <= '0;
            expired_q <= 1'b0;
        end else if (load_i) begin
            // a new load restarts the interval and drops any pending pulse
            count_q   <= load_val_i;
            expired_q <= 1'b0;
        end else begin
            // pulse lands exactly load_val cycles after the load edge
            expired_q <= (count_q == `QSFP_TIMER_WIDTH'(1));
            if (count_q != '0) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    assign expired_o = expired_q;

endmodule

`default_nettype wire

//--- hdl/port_seq_fsm.sv
// per-cage FSM stepping a QSFP module through reset, low-power init and ready
`timescale 1ns/100ps
`default_nettype none

`include "qsfp_mgmt_defines.svh"

module port_seq_fsm (
    input  wire logic                           clk_125mhz_int,
    input  wire logic                           rst_i,
    input  wire qsfp_pin_pkg::qsfp_pins_in_t    pins_i,
    input  wire logic                           expired_i,
    output logic                                load_o,
    output logic      [`QSFP_TIMER_WIDTH-1:0]   load_val_o,
    output qsfp_pin_pkg::qsfp_pins_out_t        pins_o,
    output qsfp_ctrl_pkg::port_status_t         status_o
);

    import qsfp_ctrl_pkg::*;

    localparam logic [`QSFP_TIMER_WIDTH-1:0] RESET_HOLD =
        `QSFP_TIMER_WIDTH'(`QSFP_RESET_HOLD_CYCLES);
    localparam logic [`QSFP_TIMER_WIDTH-1:0] INIT_WAIT =
        `QSFP_TIMER_WIDTH'(`QSFP_INIT_WAIT_CYCLES);

    port_state_e state_q;
    port_state_e state_d;
    logic        resetl_q;
    logic        lpmode_q;
    logic        irq_q;

    // next state and timer control
    always_comb begin
        state_d = state_q;
        load_o  = 1'b0;

        if (pins_i.modprsl_l) begin
            // a pulled module forces the empty state from any phase
            state_d = ST_ABSENT;
        end else begin
            unique case (state_q)
                ST_ABSENT: begin
                    state_d = ST_RESET;
                    load_o  = 1'b1;
                end
                ST_RESET: begin
                    if (expired_i) begin
                        state_d = ST_INIT;
                        load_o  = 1'b1;
                    end
                end
                ST_INIT: begin
                    if (expired_i) begin
                        state_d = ST_READY;
                    end
                end
                ST_READY: begin
                    state_d = ST_READY;
                end
                default: begin
                    state_d = ST_ABSENT;
                end
            endcase
        end
    end

    // reset hold is armed from the empty state, init wait otherwise
    assign load_val_o = (state_q == ST_ABSENT) ? RESET_HOLD : INIT_WAIT;

    // registered state and pin drive
    always_ff @(posedge clk_125mhz_int) begin
        if (rst_i) begin
            state_q  <= ST_ABSENT;
            resetl_q <= 1'b0;
            lpmode_q <= 1'b1;
            irq_q    <= 1'b0;
        end else begin
            state_q  <= state_d;
            // module leaves reset once init starts
            resetl_q <= (state_d == ST_INIT) || (state_d == ST_READY);
            // full power only when ready
            lpmode_q <= (state_d != ST_READY);
            irq_q    <= (state_d == ST_READY) && !pins_i.intl_l;
        end
    end

    assign pins_o.resetl   = resetl_q;
    assign pins_o.lpmode   = lpmode_q;
    assign status_o.state  = state_q;
    assign status_o.irq    = irq_q;

endmodule

`default_nettype wire

//--- hdl/led_status.sv
// per-port LED drive from sequencer status, with a shared blink prescaler
`timescale 1ns/100ps
`default_nettype none

`include "qsfp_mgmt_defines.svh"

module led_status (
    input  wire logic                                              clk_125mhz_int,
    input  wire logic                                              rst_i,
    input  wire qsfp_ctrl_pkg::port_status_t [`QSFP_PORT_CNT-1:0] status_i,
    output logic                             [`QSFP_PORT_CNT-1:0] led_o
);

    import qsfp_ctrl_pkg::*;

    // blink period is two to the power of this width
    logic [`QSFP_BLINK_BIT:0]   presc_q;
    logic [`QSFP_PORT_CNT-1:0]  led_q;

    always_ff @(posedge clk_125mhz_int) begin
        if (rst_i) begin
            presc_q <= '0;
            led_q   <= '0;
        end else begin
            presc_q <= presc_q + 1'b1;
            for (int i = 0; i < `QSFP_PORT_CNT; i++) begin
                unique case (status_i[i].state)
                    ST_ABSENT: led_q[i] <= 1'b0;
                    // blink while the module is coming up
                    ST_RESET:  led_q[i] <= presc_q[`QSFP_BLINK_BIT];
                    ST_INIT:   led_q[i] <= presc_q[`QSFP_BLINK_BIT];
                    // interrupt from a ready module turns the LED off
                    ST_READY:  led_q[i] <= !status_i[i].irq;
                    default:   led_q[i] <= 1'b0;
                endcase
            end
        end
    end

    assign led_o = led_q;

endmodule

`default_nettype wire

//--- hdl/qsfp_mgmt_top.sv
// QSFP cage management core top, one sequencer and timer per cage plus pin sync and LEDs
`timescale 1ns/100ps
`default_nettype none

`include "qsfp_mgmt_defines.svh"

module qsfp_mgmt_top (
    input  wire logic                                               clk_125mhz_int,
    input  wire logic                                               rst_i,
    input  wire qsfp_pin_pkg::qsfp_pins_in_t  [`QSFP_PORT_CNT-1:0] pins_i,
    output qsfp_pin_pkg::qsfp_pins_out_t      [`QSFP_PORT_CNT-1:0] pins_o,
    output logic                              [`QSFP_PORT_CNT-1:0] led_o
);

    import qsfp_pin_pkg::*;
    import qsfp_ctrl_pkg::*;

    qsfp_pins_in_t [`QSFP_PORT_CNT-1:0]       pins_sync;
    port_status_t  [`QSFP_PORT_CNT-1:0]       status;
    logic          [`QSFP_PORT_CNT-1:0]       timer_load;
    logic          [`QSFP_PORT_CNT-1:0][`QSFP_TIMER_WIDTH-1:0] timer_load_val;
    logic          [`QSFP_PORT_CNT-1:0]       timer_expired;

    // all cage pins share one synchronizer bus
    pin_sync #(
        .WIDTH ($bits(qsfp_pins_in_t) * `QSFP_PORT_CNT),
        .STAGES(`QSFP_SYNC_STAGES)
    ) pin_sync_i (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_i         (rst_i),
        .async_i       (pins_i),
        .sync_o        (pins_sync)
    );

    for (genvar p = 0; p < `QSFP_PORT_CNT; p++) begin : g_port
        port_seq_fsm port_seq_fsm_i (
            .clk_125mhz_int(clk_125mhz_int),
            .rst_i         (rst_i),
            .pins_i        (pins_sync[p]),
            .expired_i     (timer_expired[p]),
            .load_o        (timer_load[p]),
            .load_val_o    (timer_load_val[p]),
            .pins_o        (pins_o[p]),
            .status_o      (status[p])
        );

        port_timer port_timer_i (
            .clk_125mhz_int(clk_125mhz_int),
            .rst_i         (rst_i),
            .load_i        (timer_load[p]),
            .load_val_i    (timer_load_val[p]),
            .expired_o     (timer_expired[p])
        );
    end

    led_status led_status_i (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_i         (rst_i),
        .status_i      (status),
        .led_o         (led_o)
    );

endmodule

`default_nettype wire

//--- verification/qsfp_mgmt_tb.sv
// self-checking testbench for the QSFP cage management core, run as simulation top from the file list
`timescale 1ns/100ps
`default_nettype none

`include "qsfp_mgmt_defines.svh"

module qsfp_mgmt_tb;

    import qsfp_pin_pkg::*;

    localparam int PORTS        = `QSFP_PORT_CNT;
    localparam int CLK_HALF_NS  = 4;
    localparam int RESET_CYCLES = 5;
    localparam int LCG_SEED     = 93331;
    // samples needed to see both levels of the blink bit
    localparam int BLINK_LEN    = 1 << (`QSFP_BLINK_BIT + 1);
    // nominal delay from pin edge to ready
    localparam int LATENCY      = `QSFP_SYNC_STAGES + `QSFP_RESET_HOLD_CYCLES
                                  + `QSFP_INIT_WAIT_CYCLES + 2;
    localparam int HOLD_CHECK   = `QSFP_SYNC_STAGES + `QSFP_RESET_HOLD_CYCLES;
    localparam int INIT_CHECK   = 4;
    localparam int INIT_SAMPLE  = HOLD_CHECK + 12;
    // the two blinking rows before it already used part of the insertion latency
    localparam int READY_REST   = LATENCY + 4 - (HOLD_CHECK + INIT_CHECK + 2 * BLINK_LEN + 2);
    // sync stages, state register, LED register
    localparam int PIN_WAIT     = `QSFP_SYNC_STAGES + 3;
    localparam int STAGGER      = 25;

    localparam logic [1:0] LED_OFF   = 2'd0;
    localparam logic [1:0] LED_ON    = 2'd1;
    localparam logic [1:0] LED_BLINK = 2'd2;
    localparam logic [1:0] LED_ANY   = 2'd3;

    // cage phases used to fill the table, ordered by bring-up progress
    localparam int PH_ABSENT   = 0;
    localparam int PH_HOLD     = 1;
    localparam int PH_INIT     = 2;
    localparam int PH_INIT_ANY = 3;
    localparam int PH_READY    = 4;
    localparam int PH_IRQ      = 5;

    typedef struct packed {
        qsfp_pins_in_t [PORTS-1:0] pins;
        int                        wait_cycles;
        logic [PORTS-1:0]          exp_resetl;
        logic [PORTS-1:0]          exp_lpmode;
        logic [PORTS-1:0][1:0]     exp_led;
    } row_t;

    logic                         clk_125mhz_int = 1'b0;
    logic                         rst;
    qsfp_pins_in_t  [PORTS-1:0]   pins_in;
    qsfp_pins_out_t [PORTS-1:0]   pins_out;
    logic           [PORTS-1:0]   leds;
    row_t                         rows[$];
    bit                           table_built;
    int unsigned                  lcg_state;

    always #CLK_HALF_NS clk_125mhz_int = ~clk_125mhz_int;

    qsfp_mgmt_top qsfp_mgmt_top_i (
        .clk_125mhz_int(clk_125mhz_int),
        .rst_i         (rst),
        .pins_i        (pins_in),
        .pins_o        (pins_out),
        .led_o         (leds)
    );

    function automatic int unsigned lcg_next(int unsigned s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // every cage empty
    function automatic row_t blank_row(int wait_cycles);
        row_t r;
        for (int c = 0; c < PORTS; c++) begin
            r.pins[c].modprsl_l = 1'b1;
            r.pins[c].intl_l    = 1'b1;
            r.exp_resetl[c]     = 1'b0;
            r.exp_lpmode[c]     = 1'b1;
            r.exp_led[c]        = LED_OFF;
        end
        r.wait_cycles = wait_cycles;
        return r;
    endfunction

    // pins and expected outputs of one cage in a given phase
    function automatic row_t with_cage(row_t r, int cage, int phase);
        r.pins[cage].modprsl_l = (phase == PH_ABSENT);
        r.pins[cage].intl_l    = (phase != PH_IRQ);
        r.exp_resetl[cage]     = (phase >= PH_INIT);
        r.exp_lpmode[cage]     = (phase < PH_READY);
        case (phase)
            PH_HOLD, PH_INIT: r.exp_led[cage] = LED_BLINK;
            PH_INIT_ANY:      r.exp_led[cage] = LED_ANY;
            PH_READY:         r.exp_led[cage] = LED_ON;
            default:          r.exp_led[cage] = LED_OFF;
        endcase
        return r;
    endfunction

    function automatic bit row_blinks(row_t r);
        for (int c = 0; c < PORTS; c++) begin
            if (r.exp_led[c] == LED_BLINK) begin
                return 1'b1;
            end
        end
        return 1'b0;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("Fail at %0d ns: %s is %0h, expected %0h", $time, name, got, expected);
            $display("Test failed");
            $fatal(1, "stopping at the first mismatch");
        end
    endtask

    task automatic build_table();
        row_t r;
        int   perm[PORTS];
        int   j;
        int   tmp;
        int   elapsed;
        rows.push_back(blank_row(4));
        // cages 0 and 1 inserted together, cage 1 later serves as the bystander
        r = blank_row(HOLD_CHECK);
        r = with_cage(r, 0, PH_HOLD);
        r = with_cage(r, 1, PH_HOLD);
        rows.push_back(r);
        r.wait_cycles = INIT_CHECK;
        r = with_cage(r, 0, PH_INIT);
        r = with_cage(r, 1, PH_INIT);
        rows.push_back(r);
        r.wait_cycles = READY_REST;
        r = with_cage(r, 0, PH_READY);
        r = with_cage(r, 1, PH_READY);
        rows.push_back(r);
        // interrupt on and off again
        r.wait_cycles = PIN_WAIT;
        r = with_cage(r, 0, PH_IRQ);
        rows.push_back(r);
        r = with_cage(r, 0, PH_READY);
        rows.push_back(r);
        // removal in the middle of init, then removal of a ready cage
        r.wait_cycles = INIT_SAMPLE;
        r = with_cage(r, 2, PH_INIT);
        rows.push_back(r);
        r.wait_cycles = PIN_WAIT;
        r = with_cage(r, 2, PH_ABSENT);
        rows.push_back(r);
        r = with_cage(r, 0, PH_ABSENT);
        rows.push_back(r);
        r.wait_cycles = LATENCY + 4;
        r = with_cage(r, 0, PH_READY);
        rows.push_back(r);
        r = blank_row(PIN_WAIT);
        rows.push_back(r);
        // staggered insertions in shuffled order
        for (int i = 0; i < PORTS; i++) begin
            perm[i] = i;
        end
        for (int i = PORTS - 1; i > 0; i--) begin
            lcg_state = lcg_next(lcg_state);
            j = int'((lcg_state >> 16) % (i + 1));
            tmp = perm[i];
            perm[i] = perm[j];
            perm[j] = tmp;
        end
        for (int s = 0; s < PORTS; s++) begin
            $display("staggered insertion %0d goes to cage %0d", s, perm[s]);
            r.wait_cycles = STAGGER;
            for (int k = 0; k <= s; k++) begin
                elapsed = (s - k) * (STAGGER + 1) + STAGGER;
                r = with_cage(r, perm[k], (elapsed > LATENCY + 2) ? PH_READY : PH_INIT_ANY);
            end
            rows.push_back(r);
        end
        r.wait_cycles = LATENCY;
        for (int c = 0; c < PORTS; c++) begin
            r = with_cage(r, c, PH_READY);
        end
        rows.push_back(r);
    endtask

    task automatic apply_row(input row_t r, input int idx);
        logic [PORTS-1:0] seen_high;
        logic [PORTS-1:0] seen_low;
        @(posedge clk_125mhz_int);
        pins_in <= r.pins;
        repeat (r.wait_cycles) @(posedge clk_125mhz_int);
        @(negedge clk_125mhz_int);
        for (int c = 0; c < PORTS; c++) begin
            check_value($sformatf("row %0d pins_o[%0d].resetl", idx, c),
                        pins_out[c].resetl, r.exp_resetl[c]);
            check_value($sformatf("row %0d pins_o[%0d].lpmode", idx, c),
                        pins_out[c].lpmode, r.exp_lpmode[c]);
            if (r.exp_led[c] == LED_ON || r.exp_led[c] == LED_OFF) begin
                check_value($sformatf("row %0d led_o[%0d]", idx, c),
                            leds[c], r.exp_led[c] == LED_ON);
            end
        end
        if (row_blinks(r)) begin
            seen_high = '0;
            seen_low  = '0;
            repeat (BLINK_LEN) begin
                @(posedge clk_125mhz_int);
                @(negedge clk_125mhz_int);
                seen_high = seen_high | leds;
                seen_low  = seen_low | ~leds;
            end
            // both levels must show up within one blink period
            for (int c = 0; c < PORTS; c++) begin
                if (r.exp_led[c] == LED_BLINK) begin
                    check_value($sformatf("row %0d led_o[%0d] high/low seen", idx, c),
                                {seen_high[c], seen_low[c]}, 2'b11);
                end
            end
        end
    endtask

    initial begin
        rst = 1'b1;
        table_built = 1'b0;
        lcg_state = LCG_SEED;
        for (int c = 0; c < PORTS; c++) begin
            pins_in[c] = QSFP_PINS_IN_IDLE;
        end
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk_125mhz_int);
        @(negedge clk_125mhz_int);
        for (int c = 0; c < PORTS; c++) begin
            check_value($sformatf("reset pins_o[%0d].resetl", c), pins_out[c].resetl, 1'b0);
            check_value($sformatf("reset pins_o[%0d].lpmode", c), pins_out[c].lpmode, 1'b1);
            check_value($sformatf("reset led_o[%0d]", c), leds[c], 1'b0);
        end
        @(posedge clk_125mhz_int);
        rst <= 1'b0;
        for (int i = 0; i < rows.size(); i++) begin
            apply_row(rows[i], i);
        end
        $display("Test completed successfully");
        $finish;
    end

    // watchdog sized from the table
    initial begin
        int limit_cycles;
        wait (table_built);
        limit_cycles = RESET_CYCLES + 100;
        foreach (rows[i]) begin
            limit_cycles += rows[i].wait_cycles + 1 + (row_blinks(rows[i]) ? BLINK_LEN : 0);
        end
        #(limit_cycles * 2 * CLK_HALF_NS);
        $display("watchdog expired after %0d cycles before the table was done", limit_cycles);
        $display("Test failed");
        $fatal(1, "simulation timed out");
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+hdl
hdl/qsfp_pin_pkg.sv
hdl/qsfp_ctrl_pkg.sv
hdl/pin_sync.sv
hdl/port_timer.sv
hdl/port_seq_fsm.sv
hdl/led_status.sv
hdl/qsfp_mgmt_top.sv
verification/qsfp_mgmt_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the QSFP management testbench with Verilator.
# Exits non-zero when the build fails, the run fails, or the log reports a failure.

set -u

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log
SIM_BIN=qsfp_mgmt_sim

verilator --binary --timing -Wno-fatal \
    --top-module qsfp_mgmt_tb \
    -f tb.f \
    -o "$SIM_BIN" > "$BUILD_LOG" 2>&1
status=$?
if [ "$status" -ne 0 ]; then
    echo "verilator build failed with status $status, see $BUILD_LOG"
    exit 1
fi

if [ ! -x "obj_dir/$SIM_BIN" ]; then
    echo "simulation binary obj_dir/$SIM_BIN is missing"
    exit 1
fi

"./obj_dir/$SIM_BIN" > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"

if grep -q "Test failed" "$SIM_LOG"; then
    echo "FAIL: testbench reported a failure, see $SIM_LOG"
    exit 1
fi

if [ "$status" -ne 0 ]; then
    echo "FAIL: simulation exited with status $status"
    exit 1
fi

echo "PASS"
exit 0
